// File: src.f
+incdir+include
verilog/rv_pkg.sv
verilog/rv_fetch.sv
verilog/rv_decode.sv
verilog/rv_regs.sv
verilog/rv_hazard.sv
verilog/rv_stage_reg.sv
verilog/rv_execute.sv
verilog/rv_core.sv
tests/tb_rv_core.sv

// File: tests/tb_rv_core.sv
`timescale 1ns/1ns

`include "rv_settings.svh"

module tb_rv_core;

    localparam int CLK_PERIOD  = 100;
    localparam int N_INSTR     = 200;
    localparam int IMEM_WORDS  = 256;
    localparam int WATCHDOG_NS = N_INSTR * 6 * CLK_PERIOD * 2;

    localparam logic [6:0] OPC_R     = 7'b0110011;
    localparam logic [6:0] OPC_I     = 7'b0010011;
    localparam logic [6:0] OPC_LUI   = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC = 7'b0010111;
    localparam logic [6:0] OPC_JAL   = 7'b1101111;
    localparam logic [6:0] OPC_JALR  = 7'b1100111;
    localparam logic [6:0] OPC_BR    = 7'b1100011;

    localparam logic [`RV_IADDR_BITS-1:0] RESET_PC = `RV_RESET_ADDR;
    localparam int BASE = RESET_PC >> 2;

    typedef struct packed {
        logic [`RV_IADDR_BITS-1:0] pc;
        logic [4:0]                rd;
        logic [31:0]               data;
        logic                      reg_write;
        logic                      check_data;  // low for branches, whose rd and data carry no result
    } retire_exp_t;

    logic            clk;
    logic            arst_n;
    logic            instr_ack;
    logic [31:0]     instr_data;
    logic            instr_req;
    rv_pkg::waddr_t  instr_addr;
    rv_pkg::retire_t retire;
    logic            retire_valid;

    integer      seed = 85316;
    logic [31:0] imem [0:IMEM_WORDS-1];
    retire_exp_t exp_q [$];
    int          n_expected = 0;
    int          retired = 0;
    int          checks = 0;
    int          errors = 0;
    int          acks = 0;
    logic        first_req_seen = 1'b0;
    logic        pending;
    int          wait_left;

    rv_core DUT (
        .i_clk          (clk),
        .i_arst_n       (arst_n),
        .i_instr_ack    (instr_ack),
        .i_instr_data   (instr_data),
        .o_instr_req    (instr_req),
        .o_instr_addr   (instr_addr),
        .o_retire       (retire),
        .o_retire_valid (retire_valid)
    );

    function automatic int pick(input int lo, input int hi);
        return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
    endfunction

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_R};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BR};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    // jump distance in words, never past the closing self loop
    function automatic int fwd_words(input int i);
        int k;
        k = pick(1, 8);
        if (i + k > N_INSTR - 1)
            k = N_INSTR - 1 - i;
        return k;
    endfunction

    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: return (a < b) ? 32'd1 : 32'd0;
            3'd4: return a ^ b;
            3'd5: begin
                if (alt)
                    return $signed(a) >>> b[4:0];
                return a >> b[4:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_ref(input logic [2:0] f3, input logic [31:0] a,
                                        input logic [31:0] b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return $signed(a) < $signed(b);
            3'd5: return $signed(a) >= $signed(b);
            3'd6: return a < b;
            3'd7: return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    task automatic build_program();
        int          i;
        int          kind;
        int          k;
        int          off;
        int          tgt;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm;
        logic        hit [0:N_INSTR-1];  // slots that some jump lands on
        for (int w = 0; w < IMEM_WORDS; w++)
            imem[w] = i_type(12'(w), 5'd0, 3'd0, 5'd0, OPC_I);  // addi x0 with the word index
        for (int w = 0; w < N_INSTR; w++)
            hit[w] = 1'b0;
        i = 0;
        while (i < N_INSTR - 1) begin
            kind = pick(0, 99);
            rd   = pick(0, 5);  // few registers keep the dependences dense
            rs1  = pick(0, 5);
            rs2  = pick(0, 5);
            f3   = pick(0, 7);
            if (kind < 35) begin
                f7 = ((f3 == 3'd0 || f3 == 3'd5) && pick(0, 1) == 1) ? 7'b0100000 : 7'b0;
                imem[BASE+i] = r_type(f7, rs2, rs1, f3, rd);
            end else if (kind < 70) begin
                if (f3 == 3'd1)
                    imm = 12'(pick(0, 31));
                else if (f3 == 3'd5)
                    imm = {(pick(0, 1) == 1) ? 7'b0100000 : 7'b0, 5'(pick(0, 31))};
                else
                    imm = 12'(pick(0, 4095));
                imem[BASE+i] = i_type(imm, rs1, f3, rd, OPC_I);
            end else if (kind < 77) begin
                imem[BASE+i] = {20'(pick(0, 1048575)), rd, OPC_LUI};
            end else if (kind < 82) begin
                imem[BASE+i] = {20'(pick(0, 15)), rd, OPC_AUIPC};
            end else if (kind < 90) begin
                f3 = pick(0, 5);
                if (f3 >= 3'd2)
                    f3 = f3 + 3'd2;
                k = fwd_words(i);
                hit[i+k] = 1'b1;
                imem[BASE+i] = b_type(13'(k * 4), rs2, rs1, f3);
            end else if (kind < 95) begin
                k = fwd_words(i);
                hit[i+k] = 1'b1;
                imem[BASE+i] = j_type(21'(k * 4), rd);
            end else if (i < N_INSTR - 2 && !hit[i+1]) begin
                // base register loaded right before the jalr, so its value is forwarded
                // a jump onto the jalr itself would skip that load, hence the hit check
                rs1 = pick(1, 5);
                k   = fwd_words(i + 1);
                hit[i+1+k] = 1'b1;
                tgt = RESET_PC + (i + 1 + k) * 4;
                off = pick(0, 16) - 8;
                imem[BASE+i]   = i_type(12'(tgt - off), 5'd0, 3'd0, rs1, OPC_I);
                imem[BASE+i+1] = i_type(12'(off + pick(0, 1)), rs1, 3'd0, rd, OPC_JALR);
                i++;
            end else begin
                imem[BASE+i] = i_type(12'(pick(0, 4095)), rs1, 3'd0, rd, OPC_I);
            end
            i++;
        end
        imem[BASE+N_INSTR-1] = j_type(21'd0, 5'd0);  // the program parks in a jump to itself
    endtask

    task automatic run_model();
        logic [31:0] regs [0:31];
        logic [31:0] pc;
        logic [31:0] nxt;
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [2:0]  f3;
        logic        wr;
        logic        known;
        logic        done;
        int          steps;
        retire_exp_t e;
        for (int r = 0; r < 32; r++)
            regs[r] = 32'd0;
        pc    = 32'(RESET_PC);
        done  = 1'b0;
        steps = 0;
        while (!done) begin
            ins   = imem[pc[`RV_IADDR_BITS-1:2]];
            f3    = ins[14:12];
            a     = regs[ins[19:15]];
            b     = regs[ins[24:20]];
            nxt   = pc + 32'd4;
            res   = 32'd0;
            wr    = 1'b1;
            known = 1'b1;
            case (ins[6:0])
                OPC_R:     res = alu_ref(f3, ins[30], a, b);
                OPC_I:     res = alu_ref(f3, f3 == 3'd5 && ins[30], a,
                                         {{20{ins[31]}}, ins[31:20]});
                OPC_LUI:   res = {ins[31:12], 12'd0};
                OPC_AUIPC: res = pc + {ins[31:12], 12'd0};
                OPC_JAL: begin
                    res = pc + 32'd4;
                    nxt = pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
                end
                OPC_JALR: begin
                    res = pc + 32'd4;
                    nxt = (a + {{20{ins[31]}}, ins[31:20]}) & ~32'd1;
                end
                OPC_BR: begin
                    wr    = 1'b0;
                    known = 1'b0;
                    if (branch_ref(f3, a, b))
                        nxt = pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                end
                default: begin
                    wr    = 1'b0;
                    known = 1'b0;
                end
            endcase
            if (ins[11:7] == 5'd0)
                wr = 1'b0;
            if (wr)
                regs[ins[11:7]] = res;
            e.pc         = pc[`RV_IADDR_BITS-1:0];
            e.rd         = ins[11:7];
            e.data       = res;
            e.reg_write  = wr;
            e.check_data = known;
            exp_q.push_back(e);
            steps++;
            done = (nxt == pc) || (steps >= 2 * N_INSTR);
            pc   = nxt;
        end
    endtask

    task automatic expect_equal(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("ERR %s got %h expected %h at retire %0d", name, got, exp, retired);
        end
    endtask

    task automatic check_retire();
        retire_exp_t e;
        assert (acks > 0) else begin
            errors++;
            $display("an instruction retired before any fetch was acknowledged");
        end
        assert (exp_q.size() > 0) else begin
            errors++;
            $display("an instruction retired past the end of the expected path");
        end
        if (exp_q.size() > 0) begin
            e = exp_q.pop_front();
            retired++;
            expect_equal("o_retire.pc", 32'(retire.pc), 32'(e.pc));
            expect_equal("o_retire.reg_write", 32'(retire.reg_write), 32'(e.reg_write));
            if (e.check_data) begin
                expect_equal("o_retire.rd", 32'(retire.rd), 32'(e.rd));
                expect_equal("o_retire.data", retire.data, e.data);
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // instruction memory, answering each request after 1 to 4 cycles
    initial begin
        instr_ack  = 1'b0;
        instr_data = 32'd0;
        pending    = 1'b0;
        wait_left  = 0;
        forever begin
            @(posedge clk);
            #1;
            instr_ack = 1'b0;
            if (!arst_n) begin
                pending = 1'b0;
            end else if (instr_req) begin
                if (!first_req_seen) begin
                    first_req_seen = 1'b1;
                    checks++;
                    assert (instr_addr == RESET_PC[`RV_IADDR_BITS-1:2]) else begin
                        errors++;
                        $display("ERR o_instr_addr got %h expected %h", instr_addr,
                                 RESET_PC[`RV_IADDR_BITS-1:2]);
                    end
                end
                if (!pending) begin
                    pending   = 1'b1;
                    wait_left = pick(1, 4) - 1;
                end
                if (wait_left == 0) begin
                    assert (instr_addr < IMEM_WORDS) else begin
                        errors++;
                        $display("fetch went outside the instruction memory");
                    end
                    instr_ack  = 1'b1;
                    instr_data = imem[instr_addr[9:2]];
                    pending    = 1'b0;
                    acks++;
                end else begin
                    wait_left--;
                end
            end
        end
    end

    always @(negedge clk) begin
        if (!arst_n) begin
            assert (!retire_valid) else begin
                errors++;
                $display("the retire strobe was high during reset");
            end
        end else if (retire_valid) begin
            check_retire();
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("retirement stalled after %0d of %0d instructions", retired, n_expected);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        arst_n = 1'b0;
        build_program();
        run_model();
        n_expected = exp_q.size();
        repeat (2) @(posedge clk);
        #1 arst_n = 1'b1;
        while (retired < n_expected)
            @(negedge clk);
        repeat (2) @(negedge clk);
        $display("retired %0d of %0d, %0d checks, %0d errors", retired, n_expected,
                 checks, errors);
        if (errors == 0 && retired == n_expected)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

// File: verilog/rv_core.sv
`timescale 1ns/1ns

module rv_core (
    input  logic            i_clk,
    input  logic            i_arst_n,
    input  logic            i_instr_ack,
    input  rv_pkg::data_t   i_instr_data,
    output logic            o_instr_req,
    output rv_pkg::waddr_t  o_instr_addr,
    output rv_pkg::retire_t o_retire,
    output logic            o_retire_valid
);
    import rv_pkg::*;

    fetch_t fetch;
    logic   fetch_valid;
    reg_t   rs1;
    reg_t   rs2;
    dec_t   dec_raw;
    dec_t   dec_full;
    logic   dec_valid;
    data_t  reg_rdata1;
    data_t  reg_rdata2;
    data_t  op1;
    data_t  op2;
    dec_t   ex_dec;
    logic   ex_valid;
    wb_t    ex_wb;
    logic   ex_wb_valid;
    logic   redirect;
    pc_t    redirect_pc;
    reg_t   fwd_rd;
    logic   fwd_write;
    data_t  fwd_result;
    wb_t    wb;
    logic   wb_valid;
    logic   wb_we;

    rv_fetch u_fetch (
        .i_clk          (i_clk),
        .i_arst_n       (i_arst_n),
        .i_redirect     (redirect),
        .i_redirect_pc  (redirect_pc),
        .i_instr_ack    (i_instr_ack),
        .i_instr_data   (i_instr_data),
        .o_instr_req    (o_instr_req),
        .o_instr_addr   (o_instr_addr),
        .o_fetch        (fetch),
        .o_fetch_valid  (fetch_valid)
    );

    rv_decode u_decode (
        .i_fetch        (fetch),
        .i_fetch_valid  (fetch_valid),
        .o_rs1          (rs1),
        .o_rs2          (rs2),
        .o_dec          (dec_raw),
        .o_dec_valid    (dec_valid)
    );

    rv_regs u_regs (
        .i_clk          (i_clk),
        .i_arst_n       (i_arst_n),
        .i_rs1          (rs1),
        .i_rs2          (rs2),
        .i_we           (wb_we),
        .i_rd           (wb.rd),
        .i_wdata        (wb.result),
        .o_rdata1       (reg_rdata1),
        .o_rdata2       (reg_rdata2)
    );

    rv_hazard u_hazard (
        .i_rs1          (rs1),
        .i_rs2          (rs2),
        .i_reg_data1    (reg_rdata1),
        .i_reg_data2    (reg_rdata2),
        .i_ex_rd        (fwd_rd),
        .i_ex_write     (fwd_write),
        .i_ex_result    (fwd_result),
        .i_wb_rd        (wb.rd),
        .i_wb_write     (wb_we),
        .i_wb_data      (wb.result),
        .o_op1          (op1),
        .o_op2          (op2)
    );

    // decode leaves the operand fields empty, the forwarded values fill them here
    always_comb begin
        dec_full      = dec_raw;
        dec_full.op_a = op1;
        dec_full.op_b = op2;
    end

    rv_stage_reg #(.T(dec_t)) u_ex_reg (
        .i_clk          (i_clk),
        .i_arst_n       (i_arst_n),
        .i_flush        (redirect),
        .i_valid        (dec_valid),
        .i_data         (dec_full),
        .o_valid        (ex_valid),
        .o_data         (ex_dec)
    );

    rv_execute u_execute (
        .i_dec          (ex_dec),
        .i_dec_valid    (ex_valid),
        .o_wb           (ex_wb),
        .o_wb_valid     (ex_wb_valid),
        .o_redirect     (redirect),
        .o_redirect_pc  (redirect_pc),
        .o_fwd_rd       (fwd_rd),
        .o_fwd_write    (fwd_write),
        .o_fwd_result   (fwd_result)
    );

    rv_stage_reg #(.T(wb_t)) u_wb_reg (
        .i_clk          (i_clk),
        .i_arst_n       (i_arst_n),
        .i_flush        (1'b0),     // the jump itself always retires
        .i_valid        (ex_wb_valid),
        .i_data         (ex_wb),
        .o_valid        (wb_valid),
        .o_data         (wb)
    );

    assign wb_we = wb_valid & wb.reg_write;

    assign o_retire.pc        = wb.pc;
    assign o_retire.rd        = wb.rd;
    assign o_retire.data      = wb.result;
    assign o_retire.reg_write = wb.reg_write;
    assign o_retire_valid     = wb_valid;

endmodule

// File: verilog/rv_execute.sv
`timescale 1ns/1ns

module rv_execute (
    input  rv_pkg::dec_t    i_dec,
    input  logic            i_dec_valid,
    output rv_pkg::wb_t     o_wb,
    output logic            o_wb_valid,
    output logic            o_redirect,
    output rv_pkg::pc_t     o_redirect_pc,
    output rv_pkg::reg_t    o_fwd_rd,
    output logic            o_fwd_write,
    output rv_pkg::data_t   o_fwd_result
);
    import rv_pkg::*;

    data_t alu_a;
    data_t alu_b;
    data_t alu_out;
    data_t result;
    data_t jalr_sum;
    logic  taken;

    assign alu_a = i_dec.op_a_is_pc ? data_t'(i_dec.pc) : i_dec.op_a;
    assign alu_b = i_dec.op_b_is_imm ? i_dec.imm : i_dec.op_b;

    always_comb begin
        case (i_dec.alu_op)
            ALU_ADD:  alu_out = alu_a + alu_b;
            ALU_SUB:  alu_out = alu_a - alu_b;
            ALU_SLL:  alu_out = alu_a << alu_b[4:0];
            ALU_SLT:  alu_out = data_t'($signed(alu_a) < $signed(alu_b));
            ALU_SLTU: alu_out = data_t'(alu_a < alu_b);
            ALU_XOR:  alu_out = alu_a ^ alu_b;
            ALU_SRL:  alu_out = alu_a >> alu_b[4:0];
            ALU_SRA:  alu_out = data_t'($signed(alu_a) >>> alu_b[4:0]);
            ALU_OR:   alu_out = alu_a | alu_b;
            ALU_AND:  alu_out = alu_a & alu_b;
            default:  alu_out = alu_b;
        endcase
    end

    // branches compare the raw register operands, never the immediate
    always_comb begin
        case (i_dec.br_funct3)
            3'b000:  taken = (i_dec.op_a == i_dec.op_b);
            3'b001:  taken = (i_dec.op_a != i_dec.op_b);
            3'b100:  taken = ($signed(i_dec.op_a) < $signed(i_dec.op_b));
            3'b101:  taken = ($signed(i_dec.op_a) >= $signed(i_dec.op_b));
            3'b110:  taken = (i_dec.op_a < i_dec.op_b);
            3'b111:  taken = (i_dec.op_a >= i_dec.op_b);
            default: taken = 1'b0;
        endcase
    end

    assign jalr_sum = i_dec.op_a + i_dec.imm;
    assign result   = (i_dec.is_jal || i_dec.is_jalr) ? data_t'(i_dec.pc) + 32'd4 : alu_out;

    assign o_redirect    = i_dec_valid &
                           (i_dec.is_jal | i_dec.is_jalr | (i_dec.is_branch & taken));
    assign o_redirect_pc = i_dec.is_jalr ? (pc_t'(jalr_sum) & ~pc_t'(1))
                                         : i_dec.pc + pc_t'(i_dec.imm);

    assign o_wb.pc        = i_dec.pc;
    assign o_wb.rd        = i_dec.rd;
    assign o_wb.result    = result;
    assign o_wb.reg_write = i_dec.reg_write;
    assign o_wb_valid     = i_dec_valid;

    assign o_fwd_rd     = i_dec.rd;
    assign o_fwd_write  = i_dec_valid & i_dec.reg_write;  // bubbles never forward
    assign o_fwd_result = result;

    // a misaligned target would need a trap, which this core does not have
    redirect_aligned: assert final (!o_redirect || o_redirect_pc[1:0] == 2'b00);

endmodule

// File: verilog/rv_stage_reg.sv
`timescale 1ns/1ns

module rv_stage_reg #(
    parameter type T = logic
) (
    input  logic    i_clk,
    input  logic    i_arst_n,
    input  logic    i_flush,
    input  logic    i_valid,
    input  T        i_data,
    output logic    o_valid,
    output T        o_data
);

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_valid <= 1'b0;
            o_data  <= '0;
        end else begin
            o_valid <= i_valid & ~i_flush;  // a flushed slot becomes a bubble
            o_data  <= i_data;
        end
    end

endmodule

// File: verilog/rv_hazard.sv
`timescale 1ns/1ns

module rv_hazard (
    input  rv_pkg::reg_t    i_rs1,
    input  rv_pkg::reg_t    i_rs2,
    input  rv_pkg::data_t   i_reg_data1,
    input  rv_pkg::data_t   i_reg_data2,
    input  rv_pkg::reg_t    i_ex_rd,
    input  logic            i_ex_write,
    input  rv_pkg::data_t   i_ex_result,
    input  rv_pkg::reg_t    i_wb_rd,
    input  logic            i_wb_write,
    input  rv_pkg::data_t   i_wb_data,
    output rv_pkg::data_t   o_op1,
    output rv_pkg::data_t   o_op2
);
    import rv_pkg::*;

    // execute holds the younger producer, so it is checked first
    function automatic data_t fwd(input reg_t rs, input data_t reg_data, input reg_t ex_rd,
                                  input logic ex_write, input data_t ex_result,
                                  input reg_t wb_rd, input logic wb_write, input data_t wb_data);
        if (rs == '0)
            return reg_data;
        if (ex_write && ex_rd == rs)
            return ex_result;
        if (wb_write && wb_rd == rs)
            return wb_data;
        return reg_data;
    endfunction

    assign o_op1 = fwd(i_rs1, i_reg_data1, i_ex_rd, i_ex_write, i_ex_result,
                       i_wb_rd, i_wb_write, i_wb_data);
    assign o_op2 = fwd(i_rs2, i_reg_data2, i_ex_rd, i_ex_write, i_ex_result,
                       i_wb_rd, i_wb_write, i_wb_data);

endmodule

// File: verilog/rv_regs.sv
`timescale 1ns/1ns

`include "rv_settings.svh"

module rv_regs (
    input  logic            i_clk,
    input  logic            i_arst_n,
    input  rv_pkg::reg_t    i_rs1,
    input  rv_pkg::reg_t    i_rs2,
    input  logic            i_we,
    input  rv_pkg::reg_t    i_rd,
    input  rv_pkg::data_t   i_wdata,
    output rv_pkg::data_t   o_rdata1,
    output rv_pkg::data_t   o_rdata2
);
    import rv_pkg::*;

    localparam int NREGS = 1 << `RV_REG_BITS;

    data_t regs [1:NREGS-1];   // x0 has no storage

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 1; i < NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && i_rd != '0) begin
            regs[i_rd] <= i_wdata;
        end
    end

    assign o_rdata1 = (i_rs1 == '0) ? '0 : regs[i_rs1];
    assign o_rdata2 = (i_rs2 == '0) ? '0 : regs[i_rs2];

    no_x0_write: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_we |-> i_rd != '0);

endmodule

// File: verilog/rv_decode.sv
`timescale 1ns/1ns

module rv_decode (
    input  rv_pkg::fetch_t  i_fetch,
    input  logic            i_fetch_valid,
    output rv_pkg::reg_t    o_rs1,
    output rv_pkg::reg_t    o_rs2,
    output rv_pkg::dec_t    o_dec,
    output logic            o_dec_valid
);
    import rv_pkg::*;

    data_t      ins;
    logic [2:0] funct3;
    data_t      imm_i;
    data_t      imm_u;
    data_t      imm_b;
    data_t      imm_j;

    // funct7 bit 5 selects SUB only for register ops, SRA for both
    function automatic alu_op_t alu_sel(input logic [2:0] f3, input logic alt, input logic is_op);
        case (f3)
            3'b000:  return (alt && is_op) ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    assign ins    = i_fetch.instr;
    assign funct3 = ins[14:12];
    assign imm_i  = {{20{ins[31]}}, ins[31:20]};
    assign imm_u  = {ins[31:12], 12'b0};
    assign imm_b  = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
    assign imm_j  = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};

    assign o_rs1       = ins[19:15];
    assign o_rs2       = ins[24:20];
    assign o_dec_valid = i_fetch_valid;

    always_comb begin
        o_dec           = '0;
        o_dec.pc        = {i_fetch.pc, 2'b00};
        o_dec.rd        = ins[11:7];
        o_dec.br_funct3 = funct3;
        o_dec.alu_op    = ALU_ADD;
        case (ins[6:0])
            OPC_OP: begin
                o_dec.alu_op    = alu_sel(funct3, ins[30], 1'b1);
                o_dec.reg_write = 1'b1;
            end
            OPC_OP_IMM: begin
                o_dec.alu_op      = alu_sel(funct3, ins[30], 1'b0);
                o_dec.imm         = imm_i;
                o_dec.op_b_is_imm = 1'b1;
                o_dec.reg_write   = 1'b1;
            end
            OPC_LUI: begin
                o_dec.alu_op      = ALU_PASS_B;
                o_dec.imm         = imm_u;
                o_dec.op_b_is_imm = 1'b1;
                o_dec.reg_write   = 1'b1;
            end
            OPC_AUIPC: begin
                o_dec.imm         = imm_u;
                o_dec.op_a_is_pc  = 1'b1;
                o_dec.op_b_is_imm = 1'b1;
                o_dec.reg_write   = 1'b1;
            end
            OPC_JAL: begin
                o_dec.imm       = imm_j;
                o_dec.is_jal    = 1'b1;
                o_dec.reg_write = 1'b1;
            end
            OPC_JALR: begin
                o_dec.imm       = imm_i;
                o_dec.is_jalr   = 1'b1;
                o_dec.reg_write = 1'b1;
            end
            OPC_BRANCH: begin
                o_dec.imm       = imm_b;
                o_dec.is_branch = 1'b1;
            end
            default: ;  // anything else retires as a no-op
        endcase
        if (o_dec.rd == '0) begin
            o_dec.reg_write = 1'b0;
        end
    end

endmodule

// File: verilog/rv_fetch.sv
`timescale 1ns/1ns

`include "rv_settings.svh"

module rv_fetch (
    input  logic            i_clk,
    input  logic            i_arst_n,
    input  logic            i_redirect,
    input  rv_pkg::pc_t     i_redirect_pc,
    input  logic            i_instr_ack,
    input  rv_pkg::data_t   i_instr_data,
    output logic            o_instr_req,
    output rv_pkg::waddr_t  o_instr_addr,
    output rv_pkg::fetch_t  o_fetch,
    output logic            o_fetch_valid
);
    import rv_pkg::*;

    localparam pc_t RESET_PC = `RV_RESET_ADDR;

    logic   req_q;
    logic   discard_q;      // the outstanding request was made before a redirect
    waddr_t addr_q;
    waddr_t target_q;
    waddr_t redirect_word;

    assign redirect_word = i_redirect_pc[`RV_IADDR_BITS-1:2];

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            req_q         <= 1'b0;
            discard_q     <= 1'b0;
            addr_q        <= RESET_PC[`RV_IADDR_BITS-1:2];
            o_fetch_valid <= 1'b0;
        end else begin
            req_q         <= 1'b1;  // no back-pressure, so a request is always open
            o_fetch_valid <= 1'b0;
            if (i_redirect) begin
                if (i_instr_ack) begin
                    addr_q    <= redirect_word;
                    discard_q <= 1'b0;
                end else begin
                    discard_q <= 1'b1;  // address must hold until the old request is acked
                end
            end else if (i_instr_ack) begin
                if (discard_q) begin
                    discard_q <= 1'b0;
                    addr_q    <= target_q;
                end else begin
                    o_fetch_valid <= 1'b1;
                    addr_q        <= addr_q + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_redirect) begin
            target_q <= redirect_word;
        end
        if (i_instr_ack) begin
            o_fetch.instr <= i_instr_data;
            o_fetch.pc    <= addr_q;
        end
    end

    assign o_instr_req  = req_q;
    assign o_instr_addr = addr_q;

    ack_needs_req: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_instr_ack |-> o_instr_req);

    // the address of an open request holds until it is acknowledged
    addr_stable: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_instr_req && !i_instr_ack |=> $stable(o_instr_addr));

endmodule

// File: verilog/rv_pkg.sv
package rv_pkg;

`include "rv_settings.svh"

    typedef logic [`RV_XLEN-1:0]        data_t;
    typedef logic [`RV_REG_BITS-1:0]    reg_t;
    typedef logic [`RV_IADDR_BITS-1:0]  pc_t;      // byte address
    typedef logic [`RV_IADDR_BITS-1:2]  waddr_t;   // word address on the instruction bus

    typedef enum logic [6:0] {
        OPC_OP      = 7'b0110011,
        OPC_OP_IMM  = 7'b0010011,
        OPC_LUI     = 7'b0110111,
        OPC_AUIPC   = 7'b0010111,
        OPC_JAL     = 7'b1101111,
        OPC_JALR    = 7'b1100111,
        OPC_BRANCH  = 7'b1100011
    } opcode_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
    } alu_op_t;

    typedef struct packed {
        data_t      instr;
        waddr_t     pc;
    } fetch_t;

    typedef struct packed {
        pc_t        pc;
        data_t      op_a;           // forwarded rs1 value
        data_t      op_b;           // forwarded rs2 value
        data_t      imm;
        reg_t       rd;
        alu_op_t    alu_op;
        logic       op_a_is_pc;
        logic       op_b_is_imm;
        logic [2:0] br_funct3;
        logic       is_branch;
        logic       is_jal;
        logic       is_jalr;
        logic       reg_write;
    } dec_t;

    typedef struct packed {
        pc_t        pc;
        reg_t       rd;
        data_t      result;
        logic       reg_write;
    } wb_t;

    typedef struct packed {
        pc_t        pc;
        reg_t       rd;
        data_t      data;
        logic       reg_write;
    } retire_t;

endpackage

// File: include/rv_settings.svh
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// RV32I data path width
`define RV_XLEN         32

// five index bits give 32 architectural registers, x0 included
`define RV_REG_BITS     5

// byte address width of the instruction space, the bus itself carries word addresses
`define RV_IADDR_BITS   16

`define RV_RESET_ADDR   16'h0000

`endif
